/* dbus_uncached_top.f */
hdl/dbus_pkg.sv
hdl/axi_pkg.sv
hdl/dbus_req_stage.sv
hdl/uncached_axi_master.sv
hdl/load_align.sv
hdl/dbus_uncached_top.sv
sim/dbus_uncached_chk.sv
sim/tb_dbus_uncached.sv

/* hdl/axi_pkg.sv */
`default_nettype none

package axi_pkg;

	// Field widths of the address channels
	localparam int AXI_LEN_W   = 8;
	localparam int AXI_SIZE_W  = 3;
	localparam int AXI_BURST_W = 2;

	localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_4B    = 3'b010; // 4 bytes per beat

	// Burst length is encoded as beats minus one
	localparam logic [AXI_LEN_W-1:0]   AXI_LEN_SINGLE = 8'h00;

endpackage

`default_nettype wire

/* hdl/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

	// Access size as driven by the CPU
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

	// A data word seen whole or as four byte lanes
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] lane; // lane[0] is bits 7:0
	} lane_word_t;

endpackage

`default_nettype wire

/* hdl/dbus_req_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_req_stage
	import dbus_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         stall,
	input  logic         read,
	input  logic         write,
	input  logic         load_unsigned,
	input  access_size_t size,
	input  logic [31:0]  address,
	input  logic [31:0]  wrdata,
	output logic         pend_read,
	output logic         pend_write,
	output logic         pend_unsigned,
	output access_size_t pend_size,
	output logic [31:0]  pend_addr,
	output logic [1:0]   pend_lane,
	output lane_word_t   pend_wdata,
	output logic [3:0]   pend_strb
);

lane_word_t store_word;
logic [3:0] store_strb;

// Store data goes out on every lane it may land in
always_comb begin
	store_word.word = wrdata;
	store_strb = 4'b1111;
	case (size)
		SIZE_BYTE: begin
			for (int i = 0; i < 4; i++)
				store_word.lane[i] = wrdata[7:0];
			store_strb = 4'b0001 << address[1:0];
		end
		SIZE_HALF: begin
			for (int i = 0; i < 4; i++)
				store_word.lane[i] = (i % 2 == 1) ? wrdata[15:8] : wrdata[7:0];
			store_strb = address[1] ? 4'b1100 : 4'b0011;
		end
		default: ;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		pend_read  <= 1'b0;
		pend_write <= 1'b0;
	end else if (!stall) begin
		pend_read  <= read;
		pend_write <= write;
	end
end

// Request payload, held while stalled
always_ff @(posedge clk) begin
	if (!stall) begin
		pend_addr       <= {address[31:2], 2'b00}; // word aligned on the bus
		pend_lane       <= address[1:0];
		pend_size       <= size;
		pend_unsigned   <= load_unsigned;
		pend_wdata.word <= store_word.word;
		pend_strb       <= store_strb;
	end
end

endmodule

`default_nettype wire

/* hdl/dbus_uncached_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_uncached_top
	import dbus_pkg::*;
	import axi_pkg::*;
#(
	parameter int ID_WIDTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	// CPU data bus
	input  logic                   read,
	input  logic                   write,
	input  access_size_t           size,
	input  logic                   load_unsigned,
	input  logic [31:0]            address,
	input  logic [31:0]            wrdata,
	output logic                   stall,
	output logic [31:0]            rddata,
	// AXI master
	output logic [31:0]            araddr,
	output logic [ID_WIDTH-1:0]    arid,
	output logic [AXI_LEN_W-1:0]   arlen,
	output logic [AXI_SIZE_W-1:0]  arsize,
	output logic [AXI_BURST_W-1:0] arburst,
	output logic                   arvalid,
	input  logic                   arready,
	output logic [31:0]            awaddr,
	output logic [ID_WIDTH-1:0]    awid,
	output logic [AXI_LEN_W-1:0]   awlen,
	output logic [AXI_SIZE_W-1:0]  awsize,
	output logic [AXI_BURST_W-1:0] awburst,
	output logic                   awvalid,
	input  logic                   awready,
	output logic [31:0]            wdata,
	output logic [3:0]             wstrb,
	output logic                   wlast,
	output logic                   wvalid,
	input  logic                   wready,
	input  logic [31:0]            rdata,
	input  logic                   rvalid,
	output logic                   rready,
	input  logic                   bvalid,
	output logic                   bready
);

logic         pend_read;
logic         pend_write;
logic         pend_unsigned;
access_size_t pend_size;
logic [31:0]  pend_addr;
logic [1:0]   pend_lane;
lane_word_t   pend_wdata;
logic [3:0]   pend_strb;
logic [31:0]  beat_data;
logic         beat_load;

dbus_req_stage u_req (
	.clk, .rst, .stall,
	.read, .write, .load_unsigned, .size, .address, .wrdata,
	.pend_read, .pend_write, .pend_unsigned, .pend_size,
	.pend_addr, .pend_lane, .pend_wdata, .pend_strb
);

uncached_axi_master #(.ID_WIDTH(ID_WIDTH)) u_master (
	.clk, .rst, .pend_read, .pend_write, .pend_addr,
	.pend_wdata(pend_wdata.word),
	.pend_strb,
	.araddr, .arid, .arlen, .arsize, .arburst, .arvalid, .arready,
	.awaddr, .awid, .awlen, .awsize, .awburst, .awvalid, .awready,
	.wdata, .wstrb, .wlast, .wvalid, .wready,
	.rdata, .rvalid, .rready, .bvalid, .bready,
	.stall, .beat_data, .beat_load
);

load_align u_load (
	.clk, .rst, .beat_load, .beat_data,
	.pend_lane, .pend_size, .pend_unsigned,
	.rddata
);

endmodule

`default_nettype wire

/* hdl/load_align.sv */
`timescale 1ns/100ps
`default_nettype none

module load_align
	import dbus_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         beat_load,
	input  logic [31:0]  beat_data,
	input  logic [1:0]   pend_lane,
	input  access_size_t pend_size,
	input  logic         pend_unsigned,
	output logic [31:0]  rddata
);

lane_word_t   load_word;
logic [1:0]   load_lane;
access_size_t load_size;
logic         load_unsigned;
logic [7:0]   sel_byte;
logic [15:0]  sel_half;

// Access info kept with the word so stores in between leave rddata alone
always_ff @(posedge clk) begin
	if (rst) begin
		load_word.word <= '0;
		load_lane      <= 2'b00;
		load_size      <= SIZE_WORD;
		load_unsigned  <= 1'b0;
	end else if (beat_load) begin
		load_word.word <= beat_data;
		load_lane      <= pend_lane;
		load_size      <= pend_size;
		load_unsigned  <= pend_unsigned;
	end
end

always_comb begin
	sel_byte = load_word.lane[load_lane];
	sel_half = load_lane[1] ? {load_word.lane[3], load_word.lane[2]}
	                        : {load_word.lane[1], load_word.lane[0]};
	case (load_size)
		SIZE_BYTE: rddata = {{24{sel_byte[7] & ~load_unsigned}}, sel_byte};
		SIZE_HALF: rddata = {{16{sel_half[15] & ~load_unsigned}}, sel_half};
		default:   rddata = load_word.word;
	endcase
end

endmodule

`default_nettype wire

/* hdl/uncached_axi_master.sv */
`timescale 1ns/100ps
`default_nettype none

module uncached_axi_master
	import axi_pkg::*;
#(
	parameter int ID_WIDTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   pend_read,
	input  logic                   pend_write,
	input  logic [31:0]            pend_addr,
	input  logic [31:0]            pend_wdata,
	input  logic [3:0]             pend_strb,
	// Read address
	output logic [31:0]            araddr,
	output logic [ID_WIDTH-1:0]    arid,
	output logic [AXI_LEN_W-1:0]   arlen,
	output logic [AXI_SIZE_W-1:0]  arsize,
	output logic [AXI_BURST_W-1:0] arburst,
	output logic                   arvalid,
	input  logic                   arready,
	// Write address
	output logic [31:0]            awaddr,
	output logic [ID_WIDTH-1:0]    awid,
	output logic [AXI_LEN_W-1:0]   awlen,
	output logic [AXI_SIZE_W-1:0]  awsize,
	output logic [AXI_BURST_W-1:0] awburst,
	output logic                   awvalid,
	input  logic                   awready,
	// Write data
	output logic [31:0]            wdata,
	output logic [3:0]             wstrb,
	output logic                   wlast,
	output logic                   wvalid,
	input  logic                   wready,
	// Read data and write response
	input  logic [31:0]            rdata,
	input  logic                   rvalid,
	output logic                   rready,
	input  logic                   bvalid,
	output logic                   bready,
	output logic                   stall,
	output logic [31:0]            beat_data,
	output logic                   beat_load
);

localparam logic [2:0] ST_IDLE = 3'd0;
localparam logic [2:0] ST_ADDR = 3'd1;
localparam logic [2:0] ST_DATA = 3'd2;
localparam logic [2:0] ST_RESP = 3'd3;
localparam logic [2:0] ST_DONE = 3'd4;

logic [2:0] state, state_d;
logic       rd_op; // Current transaction is a read

always_comb begin
	state_d = state;
	case (state)
		ST_IDLE: if (pend_read || pend_write) state_d = ST_ADDR;
		ST_ADDR: if (rd_op ? arready : awready) state_d = ST_DATA;
		ST_DATA: begin
			if (rd_op && rvalid)
				state_d = ST_DONE;
			else if (!rd_op && wready)
				state_d = ST_RESP;
		end
		ST_RESP: if (bvalid) state_d = ST_DONE;
		ST_DONE: state_d = ST_IDLE;
		default: state_d = ST_IDLE;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		state <= ST_IDLE;
		rd_op <= 1'b0;
	end else begin
		state <= state_d;
		if (state == ST_IDLE)
			rd_op <= pend_read; // Read wins over write
	end
end

assign stall = (state_d != ST_IDLE);

// Single beat INCR, IDs tied to zero
assign araddr  = pend_addr;
assign arid    = '0;
assign arlen   = AXI_LEN_SINGLE;
assign arsize  = AXI_SIZE_4B;
assign arburst = AXI_BURST_INCR;
assign awaddr  = pend_addr;
assign awid    = '0;
assign awlen   = AXI_LEN_SINGLE;
assign awsize  = AXI_SIZE_4B;
assign awburst = AXI_BURST_INCR;
assign wdata   = pend_wdata;
assign wstrb   = pend_strb;

assign arvalid = (state == ST_ADDR) && rd_op;
assign awvalid = (state == ST_ADDR) && !rd_op;
assign wvalid  = (state == ST_DATA) && !rd_op;
assign wlast   = (state == ST_DATA) && !rd_op; // Only beat of the burst
assign rready  = (state == ST_DATA) && rd_op;
assign bready  = (state == ST_RESP);

assign beat_data = rdata;
assign beat_load = rready && rvalid;

endmodule

`default_nettype wire

/* sim/dbus_uncached_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_uncached_chk
	import axi_pkg::*;
(
	input logic                   clk,
	input logic                   rst,
	input logic                   arvalid,
	input logic                   arready,
	input logic                   awvalid,
	input logic                   awready,
	input logic                   wvalid,
	input logic                   wready,
	input logic                   stall,
	input logic [AXI_LEN_W-1:0]   arlen,
	input logic [AXI_LEN_W-1:0]   awlen,
	input logic [AXI_SIZE_W-1:0]  arsize,
	input logic [AXI_SIZE_W-1:0]  awsize,
	input logic [AXI_BURST_W-1:0] arburst,
	input logic [AXI_BURST_W-1:0] awburst
);

int   fail_count = 0;
logic aw_done; // AW accepted, W beat still owed

always_ff @(posedge clk) begin
	if (rst)
		aw_done <= 1'b0;
	else if (awvalid && awready)
		aw_done <= 1'b1;
	else if (wvalid && wready)
		aw_done <= 1'b0;
end

task automatic flag_failure(input string msg);
	$error("%s", msg);
	fail_count++;
endtask

a_addr_excl: assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
	else flag_failure("arvalid and awvalid high in the same cycle");
a_ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
	else flag_failure("arvalid dropped before arready");
a_aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
	else flag_failure("awvalid dropped before awready");
a_w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
	else flag_failure("wvalid dropped before wready");
a_w_after_aw: assert property (@(posedge clk) disable iff (rst) wvalid |-> aw_done)
	else flag_failure("wvalid raised before the AW handshake");
a_single_beat: assert property (@(posedge clk) disable iff (rst)
	(arvalid || awvalid) |->
	((arvalid ? {arlen, arsize, arburst} : {awlen, awsize, awburst})
		== {AXI_LEN_SINGLE, AXI_SIZE_4B, AXI_BURST_INCR}))
	else flag_failure("address channel is not a single 4-byte INCR beat");
a_reset_stall: assert property (@(posedge clk) rst |=> !stall)
	else flag_failure("stall high right after reset");

endmodule

bind uncached_axi_master dbus_uncached_chk chk_i (.*);

`default_nettype wire

/* sim/tb_dbus_uncached.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dbus_uncached
	import dbus_pkg::*;
();

localparam int CLK_PERIOD   = 100;
localparam int NUM_ACCESSES = 73; // 2 + 8 + 13 + 50

logic         clk = 1'b0;
logic         rst;
logic         read, write, load_unsigned, stall;
access_size_t size;
logic [31:0]  address, wrdata, rddata;
logic [31:0]  araddr, awaddr, wdata, rdata;
logic [3:0]   arid, awid, wstrb;
logic [7:0]   arlen, awlen;
logic [2:0]   arsize, awsize;
logic [1:0]   arburst, awburst;
logic         arvalid, arready, awvalid, awready, wlast, wvalid, wready;
logic         rvalid, rready, bvalid, bready;

logic [31:0]  mem [64];     // Slave memory
logic [31:0]  ref_mem [64]; // Expected contents
integer       seed = 32'h988ca846;
int           ar_wait, r_wait, aw_wait, w_wait, b_wait;
logic         r_pend, w_ok, b_pend, resp_seen;
logic [5:0]   r_idx, w_idx;
logic [31:0]  seen_addr;
logic [7:0]   seen_len;
logic [2:0]   seen_size;
logic [1:0]   seen_burst;
logic [3:0]   seen_id, seen_wstrb;
logic         seen_wlast;
logic [31:0]  last_load; // Expected result of the latest load
logic         load_seen;

always #(CLK_PERIOD / 2) clk = ~clk;

dbus_uncached_top #(.ID_WIDTH(4)) dbus_uncached_top_i (.*);

function automatic int pick_delay();
	return $random(seed) & 3;
endfunction

// AXI slave, each beat committed one negedge before its handshake edge
always @(negedge clk) begin
	{arready, awready, wready, rvalid, bvalid} = 5'b0;
	if (rst) begin
		{r_pend, w_ok, b_pend} = 3'b0;
		ar_wait = pick_delay();
		r_wait  = pick_delay();
		aw_wait = pick_delay();
		w_wait  = pick_delay();
		b_wait  = pick_delay();
	end else begin
		if (r_pend && rready) begin
			if (r_wait == 0) begin
				rvalid    = 1'b1;
				rdata     = mem[r_idx];
				r_pend    = 1'b0;
				resp_seen = 1'b1;
			end else
				r_wait--;
		end
		if (b_pend && bready) begin
			if (b_wait == 0) begin
				bvalid    = 1'b1;
				b_pend    = 1'b0;
				resp_seen = 1'b1;
			end else
				b_wait--;
		end
		if (w_ok && wvalid) begin
			if (w_wait == 0) begin
				wready = 1'b1;
				for (int i = 0; i < 4; i++)
					if (wstrb[i])
						mem[w_idx][8*i +: 8] = wdata[8*i +: 8];
				{seen_wstrb, seen_wlast} = {wstrb, wlast};
				w_ok   = 1'b0;
				b_pend = 1'b1;
				b_wait = pick_delay();
			end else
				w_wait--;
		end
		if (arvalid && !r_pend) begin
			if (ar_wait == 0) begin
				arready = 1'b1;
				r_idx   = araddr[7:2];
				r_pend  = 1'b1;
				{seen_addr, seen_len, seen_size, seen_burst, seen_id} =
					{araddr, arlen, arsize, arburst, arid};
				ar_wait = pick_delay();
				r_wait  = pick_delay();
			end else
				ar_wait--;
		end
		if (awvalid && !w_ok && !b_pend) begin
			if (aw_wait == 0) begin
				awready = 1'b1;
				w_idx   = awaddr[7:2];
				w_ok    = 1'b1;
				{seen_addr, seen_len, seen_size, seen_burst, seen_id} =
					{awaddr, awlen, awsize, awburst, awid};
				aw_wait = pick_delay();
				w_wait  = pick_delay();
			end else
				aw_wait--;
		end
	end
end

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		$display("Test FAILED");
		$fatal(1, "Stopped at first mismatch");
	end
endtask

// Lanes covered by the access, starting at the addressed byte
function automatic logic [3:0] expect_strb(input logic [31:0] addr, input access_size_t sz);
	logic [3:0] strb;
	int         first;
	int         nbytes;
	nbytes = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
	first  = (sz == SIZE_WORD) ? 0 : addr[1:0];
	strb   = '0;
	for (int i = 0; i < 4; i++)
		strb[i] = (i >= first) && (i < first + nbytes);
	return strb;
endfunction

function automatic logic [31:0] expect_load(input logic [31:0] addr, input access_size_t sz,
		input logic uns);
	logic [31:0] w;
	logic [7:0]  b;
	logic [15:0] h;
	w = ref_mem[addr[7:2]];
	b = w >> (8 * addr[1:0]);
	h = w >> (16 * addr[1]);
	case (sz)
		SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
		SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
		default:   return w;
	endcase
endfunction

// One CPU access, returns at the negedge where stall is low again
task automatic run_access(input logic rd, input logic [31:0] addr, input access_size_t sz,
		input logic uns, input logic [31:0] data);
	int lat;
	resp_seen     = 1'b0;
	read          = rd;
	write         = !rd;
	address       = addr;
	size          = sz;
	load_unsigned = uns;
	wrdata        = data;
	@(posedge clk);
	@(negedge clk);
	read  = 1'b0;
	write = 1'b0;
	lat   = 0;
	while (stall) begin
		@(negedge clk);
		lat++;
	end
	check_value("stall cycles >= 3", lat >= 3, 1'b1);
	check_value("response seen before stall low", resp_seen, 1'b1);
	check_value("axaddr", seen_addr, {addr[31:2], 2'b00});
	check_value("assertion failures", dbus_uncached_top_i.u_master.chk_i.fail_count, 0);
endtask

task automatic do_store(input logic [31:0] addr, input access_size_t sz,
		input logic [31:0] data);
	logic [3:0] strb;
	int         src;
	strb = expect_strb(addr, sz);
	run_access(1'b0, addr, sz, 1'b0, data);
	check_value("wstrb", seen_wstrb, strb);
	check_value("wlast", seen_wlast, 1'b1);
	if (load_seen)
		check_value("rddata after store", rddata, last_load); // Stores leave rddata alone
	for (int i = 0; i < 4; i++) begin
		src = (sz == SIZE_WORD) ? i : (sz == SIZE_HALF) ? i % 2 : 0;
		if (strb[i])
			ref_mem[addr[7:2]][8*i +: 8] = data[8*src +: 8];
	end
endtask

task automatic do_load(input logic [31:0] addr, input access_size_t sz, input logic uns);
	logic [31:0] expected;
	run_access(1'b1, addr, sz, uns, 32'h0);
	expected = expect_load(addr, sz, uns);
	check_value("rddata", rddata, expected);
	last_load = expected;
	load_seen = 1'b1;
endtask

task automatic test_word_rw();
	do_store(32'h40, SIZE_WORD, 32'hdead_beef);
	check_value("wstrb", seen_wstrb, 4'hf);
	check_value("awlen", seen_len, 8'h00);
	check_value("awsize", seen_size, 3'b010); // 4 bytes
	check_value("awburst", seen_burst, 2'b01);
	check_value("awid", seen_id, 4'h0);
	do_load(32'h40, SIZE_WORD, 1'b0);
	check_value("rddata", rddata, 32'hdead_beef);
	check_value("arid", seen_id, 4'h0);
endtask

task automatic test_byte_lanes();
	for (int lane = 0; lane < 4; lane++) begin
		do_store(32'h80 + lane, SIZE_BYTE, 32'h1234_5600 | (lane + 1));
		do_load(32'h80, SIZE_WORD, 1'b0); // Untouched lanes keep old bytes
	end
endtask

task automatic test_sign_ext();
	do_store(32'hc0, SIZE_WORD, 32'hf493_c281); // MSB set in every lane
	for (int lane = 0; lane < 4; lane++) begin
		do_load(32'hc0 + lane, SIZE_BYTE, 1'b0);
		do_load(32'hc0 + lane, SIZE_BYTE, 1'b1);
	end
	for (int h = 0; h < 4; h += 2) begin
		do_load(32'hc0 + h, SIZE_HALF, 1'b0);
		do_load(32'hc0 + h, SIZE_HALF, 1'b1);
	end
	check_value("rddata", rddata, 32'h0000_f493);
endtask

task automatic test_random();
	logic [31:0]  addr;
	int unsigned  r;
	access_size_t sz;
	for (int n = 0; n < 50; n++) begin
		r    = $random(seed);
		sz   = access_size_t'(r % 3);
		addr = $random(seed) & 32'hff;
		if (sz == SIZE_HALF)
			addr[0] = 1'b0;
		else if (sz == SIZE_WORD)
			addr[1:0] = 2'b00;
		if ($random(seed) & 1)
			do_load(addr, sz, $random(seed) & 1);
		else
			do_store(addr, sz, $random(seed));
	end
endtask

initial begin
	#((NUM_ACCESSES * 40 + 10) * CLK_PERIOD);
	$display("[ERROR] timeout, an access never completed");
	$display("Test FAILED");
	$fatal(1, "Watchdog expired");
end

initial begin
	rst           = 1'b1;
	read          = 1'b0;
	write         = 1'b0;
	load_unsigned = 1'b0;
	size          = SIZE_WORD;
	address       = '0;
	wrdata        = '0;
	rdata         = '0;
	resp_seen     = 1'b0;
	load_seen     = 1'b0;
	last_load     = '0;
	{arready, awready, wready, rvalid, bvalid} = 5'b0;
	for (int i = 0; i < 64; i++) begin
		mem[i]     = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
		ref_mem[i] = mem[i];
	end
	repeat (3) @(negedge clk);
	rst = 1'b0;
	test_word_rw();
	test_byte_lanes();
	test_sign_ext();
	test_random();
	$display("Test OK");
	$finish;
end

endmodule

`default_nettype wire
